// ==== compile.f ====
hdl/obi_pkg.sv
hdl/irq_ctrl.sv
hdl/mul_coproc.sv
hdl/obi_core.sv
hdl/cpu_subsystem.sv
verif/tb_mem_model.sv
verif/tb_cpu_subsystem.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds and runs the testbench with Verilator, then scans the log for failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_cpu_subsystem \
  --Mdir obj_dir -o sim_tb > build.log 2>&1 \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || { echo "build or run error, see build.log and sim.log"; exit 1; }

grep -q "sim failed" sim.log && { echo "simulation reported failure"; exit 1; } \
  || { echo "simulation finished without failure"; exit 0; }

// ==== verif/tb_cpu_subsystem.sv ====
`timescale 1ns/10ps

module tb_cpu_subsystem;
  import obi_pkg::*;

  localparam time         CLK_PERIOD = 8ns;
  localparam int          NUM_TESTS  = 5;
  localparam logic [31:0] BOOT       = 32'h180;
  localparam logic [31:0] MARKER     = 32'hFFC;

  logic        clk = 1'b0;
  logic        arst_n;
  logic [31:0] irq;
  logic        fetch_enable;
  logic        debug_req;
  logic        irq_ack;
  logic [4:0]  irq_id;
  obi_req_t    instr_req;
  obi_resp_t   instr_resp;
  obi_req_t    data_req;
  obi_resp_t   data_resp;

  int          errors;
  int          test_errors;
  int          passed;
  int          failed;
  int          ack_count;
  logic [4:0]  ack_id;
  logic [31:0] post_ack_addr;

  always #(CLK_PERIOD / 2) clk = ~clk;

  cpu_subsystem #(.BOOT_ADDR(BOOT)) dut (
    .clk_i            (clk),
    .arst_n_i         (arst_n),
    .core_instr_req_o (instr_req),
    .core_instr_resp_i(instr_resp),
    .core_data_req_o  (data_req),
    .core_data_resp_i (data_resp),
    .irq_i            (irq),
    .irq_ack_o        (irq_ack),
    .irq_id_o         (irq_id),
    .debug_req_i      (debug_req),
    .fetch_enable_i   (fetch_enable)
  );

  tb_mem_model mem (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .instr_req_i (instr_req),
    .instr_resp_o(instr_resp),
    .data_req_i  (data_req),
    .data_resp_o (data_resp)
  );

  // The vector fetch is already up in the ack cycle
  always @(negedge clk) begin
    if (irq_ack) begin
      ack_count++;
      ack_id        = irq_id;
      post_ack_addr = instr_req.req ? instr_req.addr : 32'hxxxxxxxx;
    end
  end

  initial begin
    #(NUM_TESTS * 2000 * CLK_PERIOD);
    $display("Watchdog expired before the tests completed");
    $display("sim failed");
    $finish;
  end

  task automatic check_word(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_id(string name, logic [4:0] got, logic [4:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_req(string name, obi_req_t got, obi_req_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  function automatic logic [31:0] enc(opcode_e op, int rd, int rs, logic [15:0] imm);
    return {op, 2'(rd), 2'(rs), 8'h00, imm};
  endfunction

  // Program words from BOOT onward
  task automatic put(int idx, logic [31:0] word);
    mem.imem[(BOOT >> 2) + idx] = word;
  endtask

  task automatic put_at(logic [31:0] addr, logic [31:0] word);
    mem.imem[addr[11:2]] = word;
  endtask

  task automatic begin_test(logic enable, logic halt);
    @(negedge clk);
    arst_n       = 1'b0;
    irq          = '0;
    fetch_enable = enable;
    debug_req    = halt;
    ack_count    = 0;
    test_errors  = 0;
    for (int i = 0; i < 1024; i++) begin
      mem.imem[i] = '0;
      mem.dmem[i] = (i * 32'h9E3779B1) ^ 32'h5A5A0000;
    end
    mem.fetch_log.delete();
    mem.store_addr.delete();
    mem.store_data.delete();
  endtask

  task automatic release_reset();
    repeat (3) @(negedge clk);
    arst_n = 1'b1;
  endtask

  function automatic int store_count(logic [31:0] addr);
    int n;
    n = 0;
    foreach (mem.store_addr[i]) if (mem.store_addr[i] == addr) n++;
    return n;
  endfunction

  // Data of the nth store to addr or x when missing
  function automatic logic [31:0] store_value(logic [31:0] addr, int nth);
    int n;
    n = 0;
    foreach (mem.store_addr[i]) begin
      if (mem.store_addr[i] == addr) begin
        if (n == nth) return mem.store_data[i];
        n++;
      end
    end
    return 32'hxxxxxxxx;
  endfunction

  task automatic wait_marker();
    while (store_count(MARKER) == 0) @(negedge clk);
  endtask

  task automatic end_test(string name);
    $display("%s: %s", name, (test_errors == 0) ? "ok" : "FAILED");
    if (test_errors == 0) passed++;
    else failed++;
  endtask

  task automatic test_boot();
    obi_req_t exp;
    int       early;
    begin_test(1'b0, 1'b0);
    put(0, enc(OP_LI, 0, 0, 16'h0001));
    put(1, enc(OP_SW, 0, 0, MARKER[15:0]));
    release_reset();
    early = 0;
    repeat (6) begin
      @(negedge clk);
      if (instr_req.req) early++;
    end
    // Halt first so that run never rises here
    debug_req    = 1'b1;
    fetch_enable = 1'b1;
    repeat (6) begin
      @(negedge clk);
      if (instr_req.req) early++;
    end
    if (early != 0) begin
      $display("Fetch request seen while fetching was disabled or halted");
      errors++;
      test_errors++;
    end
    debug_req = 1'b0;
    @(negedge clk);
    while (!instr_req.req) @(negedge clk);
    exp = '{req: 1'b1, we: 1'b0, be: 4'hF, addr: BOOT, wdata: 32'h0};
    check_req("first instr req", instr_req, exp);
    wait_marker();
    end_test("boot");
  endtask

  task automatic test_arith();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] s0;
    logic [31:0] s1;
    a  = 32'h1234;
    b  = 32'hF00D;
    s0 = a + b;
    s1 = b + s0;
    begin_test(1'b1, 1'b0);
    put(0, enc(OP_LI, 0, 0, a[15:0]));
    put(1, enc(OP_LI, 1, 0, b[15:0]));
    put(2, enc(OP_ADD, 0, 1, 16'h0));
    put(3, enc(OP_SW, 0, 0, 16'h300));
    put(4, enc(OP_ADD, 1, 0, 16'h0));
    put(5, enc(OP_SW, 1, 0, 16'h304));
    put(6, enc(OP_ADD, 1, 1, 16'h0));
    put(7, enc(OP_SW, 1, 0, 16'h308));
    put(8, enc(OP_LI, 2, 0, 16'h1));
    put(9, enc(OP_SW, 2, 0, MARKER[15:0]));
    release_reset();
    wait_marker();
    check_word("store 0x300", store_value(32'h300, 0), s0);
    check_word("store 0x304", store_value(32'h304, 0), s1);
    check_word("store 0x308", store_value(32'h308, 0), s1 + s1);
    end_test("arith");
  endtask

  task automatic test_loop();
    int n;
    n = 5;
    begin_test(1'b1, 1'b0);
    mem.dmem[32'h400 >> 2] = n;
    mem.dmem[32'h404 >> 2] = 32'hFFFFFFFF;
    put(0, enc(OP_LW, 0, 0, 16'h400));
    put(1, enc(OP_LW, 1, 0, 16'h404));
    put(2, enc(OP_SW, 0, 0, 16'h500));
    put(3, enc(OP_ADD, 0, 1, 16'h0));
    put(4, enc(OP_BNZ, 0, 0, BOOT[15:0] + 16'd8));
    put(5, enc(OP_SW, 0, 0, 16'h504));
    put(6, enc(OP_LI, 2, 0, 16'h1));
    put(7, enc(OP_SW, 2, 0, MARKER[15:0]));
    release_reset();
    wait_marker();
    check_word("loop store count", store_count(32'h500), n);
    for (int i = 0; i < n; i++) begin
      check_word("loop store 0x500", store_value(32'h500, i), n - i);
    end
    check_word("final store 0x504", store_value(32'h504, 0), 32'h0);
    end_test("loop");
  endtask

  task automatic test_mul();
    logic [31:0] a;
    logic [31:0] b;
    a = 32'h80000003;
    b = 32'h7FFFFFF5;
    begin_test(1'b1, 1'b0);
    mem.dmem[32'h400 >> 2] = a;
    mem.dmem[32'h404 >> 2] = b;
    mem.dmem[32'h408 >> 2] = 32'h0;
    put(0, enc(OP_LW, 0, 0, 16'h400));
    put(1, enc(OP_LW, 1, 0, 16'h404));
    put(2, enc(OP_MUL, 0, 1, 16'h0));
    put(3, enc(OP_SW, 0, 0, 16'h500));
    put(4, enc(OP_LW, 2, 0, 16'h408));
    put(5, enc(OP_MUL, 1, 2, 16'h0));
    put(6, enc(OP_SW, 1, 0, 16'h504));
    put(7, enc(OP_LW, 3, 0, 16'h400));
    put(8, enc(OP_MUL, 3, 3, 16'h0));
    put(9, enc(OP_SW, 3, 0, 16'h508));
    put(10, enc(OP_LI, 2, 0, 16'h1));
    put(11, enc(OP_SW, 2, 0, MARKER[15:0]));
    release_reset();
    wait_marker();
    check_word("mul a*b", store_value(32'h500, 0), a * b);
    check_word("mul b*0", store_value(32'h504, 0), 32'h0);
    check_word("mul a*a", store_value(32'h508, 0), a * a);
    end_test("mul");
  endtask

  task automatic test_irq();
    obi_req_t exp_store;
    int       reti_idx;
    begin_test(1'b1, 1'b0);
    put(0, enc(OP_LI, 0, 0, 16'h5));
    put(1, enc(OP_SW, 0, 0, 16'h300));
    put(2, enc(OP_LI, 1, 0, 16'h7));
    put(3, enc(OP_ADD, 0, 1, 16'h0));
    put(4, enc(OP_SW, 0, 0, 16'h304));
    put(5, enc(OP_LI, 2, 0, 16'h1));
    put(6, enc(OP_SW, 2, 0, MARKER[15:0]));
    put_at(IRQ_VECTOR, enc(OP_LI, 3, 0, 16'h00AB));
    put_at(IRQ_VECTOR + 4, enc(OP_SW, 3, 0, 16'h200));
    put_at(IRQ_VECTOR + 8, enc(OP_RETI, 0, 0, 16'h0));
    release_reset();
    // Raise lines while the core sits in the first store
    while (!(data_req.req && data_req.addr == 32'h300)) @(negedge clk);
    exp_store = '{req: 1'b1, we: 1'b1, be: 4'hF, addr: 32'h300, wdata: 32'h5};
    check_req("store req 0x300", data_req, exp_store);
    irq = 32'h00000A40;
    while (ack_count == 0) @(negedge clk);
    // The other lines stay up while the handler runs
    irq[ack_id] = 1'b0;
    check_id("irq_id_o", ack_id, 5'd6);
    check_word("fetch after ack", post_ack_addr, IRQ_VECTOR);
    while (store_count(32'h200) == 0) @(negedge clk);
    check_word("acks during handler", ack_count, 1);
    irq = '0;
    wait_marker();
    check_word("irq_ack_o pulses", ack_count, 1);
    check_word("handler store", store_value(32'h200, 0), 32'hAB);
    check_word("store 0x304", store_value(32'h304, 0), 32'd12);
    reti_idx = -1;
    foreach (mem.fetch_log[i]) begin
      if (reti_idx < 0 && mem.fetch_log[i] == IRQ_VECTOR + 8) reti_idx = i;
    end
    if (reti_idx < 0 || reti_idx + 1 >= mem.fetch_log.size()) begin
      $display("No fetch found after the return from interrupt");
      errors++;
      test_errors++;
    end else begin
      check_word("resume address", mem.fetch_log[reti_idx + 1], BOOT + 32'd8);
    end
    end_test("irq");
  endtask

  initial begin
    arst_n       = 1'b0;
    irq          = '0;
    fetch_enable = 1'b0;
    debug_req    = 1'b0;
    errors       = 0;
    passed       = 0;
    failed       = 0;
    ack_count    = 0;
    test_boot();
    test_arith();
    test_loop();
    test_mul();
    test_irq();
    $display("tests passed %0d, tests failed %0d, errors %0d", passed, failed, errors);
    if (errors == 0 && failed == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== verif/tb_mem_model.sv ====
`timescale 1ns/10ps

module tb_mem_model (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  obi_pkg::obi_req_t  instr_req_i,
  output obi_pkg::obi_resp_t instr_resp_o,
  input  obi_pkg::obi_req_t  data_req_i,
  output obi_pkg::obi_resp_t data_resp_o
);
  import obi_pkg::*;

  // Word arrays, indexed by address bits 11:2
  logic [31:0] imem [1024];
  logic [31:0] dmem [1024];

  logic [31:0] fetch_log [$];
  logic [31:0] store_addr [$];
  logic [31:0] store_data [$];

  logic [31:0] lfsr_state = 32'h78b11ef7;
  int          i_stall = -1;
  int          d_stall = -1;
  logic        i_pend;
  logic        d_pend;
  logic [31:0] i_rdata;
  logic [31:0] d_rdata;
  obi_resp_t   ir;
  obi_resp_t   dr;

  // Galois LFSR, one step per bit
  function automatic logic lfsr_next_bit();
    logic lsb;
    lsb = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (lsb) lfsr_state = lfsr_state ^ 32'hD0000001;
    return lsb;
  endfunction

  // Grant delay of 0 to 3 cycles
  function automatic int draw_stall();
    logic b0;
    logic b1;
    b0 = lfsr_next_bit();
    b1 = lfsr_next_bit();
    return int'({b1, b0});
  endfunction

  always @(negedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      instr_resp_o <= '0;
      data_resp_o  <= '0;
      i_pend  = 1'b0;
      d_pend  = 1'b0;
      i_stall = -1;
      d_stall = -1;
    end else begin
      ir = '0;
      if (i_pend) begin
        ir.rvalid = 1'b1;
        ir.rdata  = i_rdata;
        i_pend    = 1'b0;
      end else if (instr_req_i.req) begin
        if (i_stall < 0) i_stall = draw_stall();
        if (i_stall == 0) begin
          ir.gnt  = 1'b1;
          i_pend  = 1'b1;
          i_stall = -1;
          i_rdata = imem[instr_req_i.addr[11:2]];
          fetch_log.push_back(instr_req_i.addr);
        end else begin
          i_stall--;
        end
      end
      instr_resp_o <= ir;

      dr = '0;
      if (d_pend) begin
        dr.rvalid = 1'b1;
        dr.rdata  = d_rdata;
        d_pend    = 1'b0;
      end else if (data_req_i.req) begin
        if (d_stall < 0) d_stall = draw_stall();
        if (d_stall == 0) begin
          dr.gnt  = 1'b1;
          d_pend  = 1'b1;
          d_stall = -1;
          d_rdata = dmem[data_req_i.addr[11:2]];
          if (data_req_i.we) begin
            dmem[data_req_i.addr[11:2]] = data_req_i.wdata;
            store_addr.push_back(data_req_i.addr);
            store_data.push_back(data_req_i.wdata);
          end
        end else begin
          d_stall--;
        end
      end
      data_resp_o <= dr;
    end
  end

endmodule

// ==== hdl/cpu_subsystem.sv ====
`timescale 1ns/10ps

module cpu_subsystem #(
  parameter logic [31:0] BOOT_ADDR = 32'h180
) (
  input  logic               clk_i,
  input  logic               arst_n_i,

  // Instruction memory port
  output obi_pkg::obi_req_t  core_instr_req_o,
  input  obi_pkg::obi_resp_t core_instr_resp_i,

  // Data memory port
  output obi_pkg::obi_req_t  core_data_req_o,
  input  obi_pkg::obi_resp_t core_data_resp_i,

  // Interrupt lines and acknowledge
  input  logic [31:0]        irq_i,
  output logic               irq_ack_o,
  output logic [4:0]         irq_id_o,

  // Halt request, treated like fetch enable low
  input  logic               debug_req_i,

  input  logic               fetch_enable_i
);
  import obi_pkg::*;

  apu_req_t  apu_req;
  apu_resp_t apu_resp;
  logic      core_run;
  logic      irq_pending;
  logic      irq_take;
  logic      irq_done;

  assign core_run = fetch_enable_i & ~debug_req_i;

  // Instruction port only reads
  assign core_instr_req_o.we    = 1'b0;
  assign core_instr_req_o.wdata = '0;
  assign core_instr_req_o.be    = 4'b1111;

  obi_core u_core (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .boot_addr_i  (BOOT_ADDR),
    .run_i        (core_run),
    .instr_addr_o (core_instr_req_o.addr),
    .instr_req_o  (core_instr_req_o.req),
    .instr_resp_i (core_instr_resp_i),
    .data_req_o   (core_data_req_o),
    .data_resp_i  (core_data_resp_i),
    .apu_req_o    (apu_req),
    .apu_resp_i   (apu_resp),
    .irq_pending_i(irq_pending),
    .irq_take_o   (irq_take),
    .irq_done_o   (irq_done)
  );

  mul_coproc u_mul (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .apu_req_i (apu_req),
    .apu_resp_o(apu_resp)
  );

  irq_ctrl u_irq (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .irq_i        (irq_i),
    .irq_take_i   (irq_take),
    .irq_done_i   (irq_done),
    .irq_pending_o(irq_pending),
    .irq_ack_o    (irq_ack_o),
    .irq_id_o     (irq_id_o)
  );

endmodule

// ==== hdl/obi_core.sv ====
`timescale 1ns/10ps

module obi_core (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic [31:0]        boot_addr_i,
  input  logic               run_i,
  output logic [31:0]        instr_addr_o,
  output logic               instr_req_o,
  input  obi_pkg::obi_resp_t instr_resp_i,
  output obi_pkg::obi_req_t  data_req_o,
  input  obi_pkg::obi_resp_t data_resp_i,
  output obi_pkg::apu_req_t  apu_req_o,
  input  obi_pkg::apu_resp_t apu_resp_i,
  input  logic               irq_pending_i,
  output logic               irq_take_o,
  output logic               irq_done_o
);
  import obi_pkg::*;

  typedef enum logic [2:0] {
    FETCH,
    FETCH_WAIT,
    EXEC,
    MEM,
    MEM_WAIT,
    APU,
    APU_WAIT
  } state_e;

  state_e                    state_q;
  state_e                    state_d;
  logic [31:0]               pc_q;
  logic [31:0]               pc_d;
  logic [31:0]               epc_q;
  logic                      fetch_hold_q;
  logic                      started_q;
  instr_t                    instr_q;
  logic [NUM_REGS-1:0][31:0] rf_q;
  logic [31:0]               rd_val;
  logic [31:0]               rs_val;
  logic [31:0]               imm_ext;
  logic                      rf_we;
  logic [31:0]               rf_wdata;
  logic                      fetch_en;
  logic                      fetch_idle;

  assign rd_val  = rf_q[instr_q.rd];
  assign rs_val  = rf_q[instr_q.rs];
  assign imm_ext = {16'h0000, instr_q.imm};

  // Fetching starts in the first cycle after reset release
  assign fetch_en = run_i && started_q;

  // At an instruction boundary with no fetch request left hanging
  assign fetch_idle = (state_q == FETCH) && !fetch_hold_q && fetch_en;

  // Interrupt entry replaces the fetch for one cycle
  assign irq_take_o  = fetch_idle && irq_pending_i;
  assign instr_req_o = (state_q == FETCH) && (fetch_hold_q || (fetch_en && !irq_pending_i));
  assign instr_addr_o = pc_q;

  assign irq_done_o = (state_q == EXEC) && (instr_q.opcode == OP_RETI);

  // Data port fields stay stable while in MEM
  assign data_req_o.req   = (state_q == MEM);
  assign data_req_o.we    = (instr_q.opcode == OP_SW);
  assign data_req_o.be    = 4'b1111;
  assign data_req_o.addr  = imm_ext;
  assign data_req_o.wdata = rd_val;

  assign apu_req_o.req  = (state_q == APU);
  assign apu_req_o.op_a = rd_val;
  assign apu_req_o.op_b = rs_val;

  always_comb begin
    state_d  = state_q;
    pc_d     = pc_q;
    rf_we    = 1'b0;
    rf_wdata = '0;
    case (state_q)
      FETCH: begin
        if (irq_take_o) begin
          pc_d = IRQ_VECTOR;
        end else if (instr_req_o && instr_resp_i.gnt) begin
          state_d = FETCH_WAIT;
        end
      end
      FETCH_WAIT: begin
        if (instr_resp_i.rvalid) state_d = EXEC;
      end
      EXEC: begin
        pc_d    = pc_q + 32'd4;
        state_d = FETCH;
        case (instr_q.opcode)
          OP_LI: begin
            rf_we    = 1'b1;
            rf_wdata = imm_ext;
          end
          OP_ADD: begin
            rf_we    = 1'b1;
            rf_wdata = rd_val + rs_val;
          end
          OP_LW, OP_SW: state_d = MEM;
          OP_MUL:       state_d = APU;
          OP_BNZ: begin
            if (rd_val != '0) pc_d = imm_ext;
          end
          OP_RETI: pc_d = epc_q;
          default: ;
        endcase
      end
      MEM: begin
        if (data_resp_i.gnt) state_d = MEM_WAIT;
      end
      MEM_WAIT: begin
        if (data_resp_i.rvalid) begin
          state_d = FETCH;
          // Store also waits here for its response
          if (instr_q.opcode == OP_LW) begin
            rf_we    = 1'b1;
            rf_wdata = data_resp_i.rdata;
          end
        end
      end
      APU: begin
        if (apu_resp_i.gnt) state_d = APU_WAIT;
      end
      APU_WAIT: begin
        if (apu_resp_i.rvalid) begin
          state_d  = FETCH;
          rf_we    = 1'b1;
          rf_wdata = apu_resp_i.result;
        end
      end
      default: state_d = FETCH;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q      <= FETCH;
      pc_q         <= boot_addr_i;
      fetch_hold_q <= 1'b0;
      started_q    <= 1'b0;
      rf_q         <= '0;
    end else begin
      state_q      <= state_d;
      pc_q         <= pc_d;
      started_q    <= 1'b1;
      // Keep req up once issued, even if run drops before the grant
      fetch_hold_q <= instr_req_o && !instr_resp_i.gnt;
      if (rf_we) begin
        rf_q[instr_q.rd] <= rf_wdata;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (irq_take_o) begin
      epc_q <= pc_q;
    end
    if ((state_q == FETCH_WAIT) && instr_resp_i.rvalid) begin
      instr_q <= instr_t'(instr_resp_i.rdata);
    end
  end

endmodule

// ==== hdl/mul_coproc.sv ====
`timescale 1ns/10ps

module mul_coproc (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  obi_pkg::apu_req_t  apu_req_i,
  output obi_pkg::apu_resp_t apu_resp_o
);
  import obi_pkg::*;

  localparam int CNT_W = $clog2(MUL_STEPS);

  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    DONE
  } state_e;

  state_e      state_q;
  logic [CNT_W-1:0] step_q;
  logic [31:0] mcand_q;
  logic [31:0] mplr_q;
  logic [31:0] acc_q;
  logic [31:0] pp;
  logic        accept;

  assign accept = (state_q == IDLE) && apu_req_i.req;

  // Radix-4 partial product of the two lowest multiplier bits
  always_comb begin
    case (mplr_q[1:0])
      2'd0:    pp = '0;
      2'd1:    pp = mcand_q;
      2'd2:    pp = mcand_q << 1;
      default: pp = mcand_q + (mcand_q << 1);
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
      step_q  <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          step_q <= '0;
          if (accept) state_q <= BUSY;
        end
        BUSY: begin
          step_q <= step_q + 1'b1;
          if (step_q == CNT_W'(MUL_STEPS - 1)) state_q <= DONE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Operand shifters and accumulator
  always_ff @(posedge clk_i) begin
    if (accept) begin
      mcand_q <= apu_req_i.op_a;
      mplr_q  <= apu_req_i.op_b;
      acc_q   <= '0;
    end else if (state_q == BUSY) begin
      acc_q   <= acc_q + pp;
      mcand_q <= mcand_q << 2;
      mplr_q  <= mplr_q >> 2;
    end
  end

  assign apu_resp_o.gnt    = (state_q == IDLE);
  assign apu_resp_o.rvalid = (state_q == DONE);
  assign apu_resp_o.result = acc_q;

endmodule

// ==== hdl/irq_ctrl.sv ====
`timescale 1ns/10ps

module irq_ctrl (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic [obi_pkg::IRQ_NUM-1:0] irq_i,
  input  logic                        irq_take_i,
  input  logic                        irq_done_i,
  output logic                        irq_pending_o,
  output logic                        irq_ack_o,
  output logic [4:0]                  irq_id_o
);
  import obi_pkg::*;

  logic [4:0] sel_id;
  logic       active_q;
  logic       ack_q;
  logic [4:0] id_q;

  // Lowest numbered line wins, so scan from the top down
  always_comb begin
    sel_id = '0;
    for (int i = IRQ_NUM - 1; i >= 0; i--) begin
      if (irq_i[i]) begin
        sel_id = 5'(i);
      end
    end
  end

  // No nesting while a handler runs
  assign irq_pending_o = (|irq_i) & ~active_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      active_q <= 1'b0;
      ack_q    <= 1'b0;
      id_q     <= '0;
    end else begin
      ack_q <= irq_take_i;
      if (irq_take_i) begin
        id_q     <= sel_id;
        active_q <= 1'b1;
      end else if (irq_done_i) begin
        active_q <= 1'b0;
      end
    end
  end

  assign irq_ack_o = ack_q;
  assign irq_id_o  = id_q;

endmodule

// ==== hdl/obi_pkg.sv ====
package obi_pkg;

  // OBI request and response, one set per memory port
  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
  } obi_resp_t;

  // Auxiliary unit link between core and multiplier
  typedef struct packed {
    logic        req;
    logic [31:0] op_a;
    logic [31:0] op_b;
  } apu_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] result;
  } apu_resp_t;

  // Opcode field in bits 31:28
  typedef enum logic [3:0] {
    OP_NOP  = 4'h0,
    OP_LI   = 4'h1,
    OP_ADD  = 4'h2,
    OP_LW   = 4'h3,
    OP_SW   = 4'h4,
    OP_MUL  = 4'h5,
    OP_BNZ  = 4'h6,
    OP_RETI = 4'h7
  } opcode_e;

  localparam int REG_IDX_W = 2;
  localparam int NUM_REGS  = 2 ** REG_IDX_W;

  // Instruction word layout, bits 23:16 carry nothing
  typedef struct packed {
    opcode_e                opcode;
    logic [REG_IDX_W-1:0]   rd;
    logic [REG_IDX_W-1:0]   rs;
    logic [7:0]             rsvd;
    logic [15:0]            imm;
  } instr_t;

  localparam logic [31:0] IRQ_VECTOR = 32'h100;
  localparam int          IRQ_NUM    = 32;
  localparam int          MUL_STEPS  = 16;

endpackage
